// ==== common/minerPkg.sv ====
package minerPkg;

	// header words, targets and hash values.
	typedef logic [31:0] hashWord_t;

	// full nonce as seen by the reader.
	typedef logic [31:0] nonce_t;

	// one pipeline stage per round in every core.
	localparam int MIX_ROUNDS = 4;

	localparam hashWord_t MIX_CONST = 32'h9E3779B9; // scaled by round number + 1.

	typedef enum logic {
		STORE_IDLE,
		STORE_BROADCAST
	} storeState_t;

endpackage

// ==== src/blockStore.sv ====
`timescale 1ns/1ps

module blockStore import minerPkg::*; #(
	parameter int BROADCAST_CNT = 16
) (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      loadBlock_i,
	input  hashWord_t header_i,
	input  hashWord_t target_i,
	output logic      stepValid_o,
	output logic      newBlock_o,
	output hashWord_t header_o,
	output hashWord_t target_o
);
	localparam int CNT_W = $clog2(BROADCAST_CNT + 1);

	storeState_t state;
	logic [CNT_W-1:0] stepCnt;
	logic lastStep;

	assign lastStep = (stepCnt == CNT_W'(BROADCAST_CNT - 1));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= STORE_IDLE;
			stepCnt <= '0;
			stepValid_o <= 1'b0;
			newBlock_o <= 1'b0;
		end else if (loadBlock_i) begin
			state <= STORE_BROADCAST; // also restarts a running broadcast.
			stepCnt <= '0;
			stepValid_o <= 1'b1;
			newBlock_o <= 1'b1;
		end else if (state == STORE_BROADCAST) begin
			newBlock_o <= 1'b0;
			if (lastStep) begin
				state <= STORE_IDLE;
				stepValid_o <= 1'b0;
			end else begin
				stepCnt <= stepCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (loadBlock_i) begin
			header_o <= header_i;
			target_o <= target_i;
		end
	end

	assert property (@(posedge clk) disable iff (rst_i)
		(state == STORE_IDLE) |-> !stepValid_o);

endmodule

// ==== lattice/latticeCore.sv ====
`timescale 1ns/1ps

module latticeCore import minerPkg::*; #(
	parameter int NUM_CORES = 4,
	parameter int INDEX = 0,
	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             stepValid_i,
	input  logic             newBlock_i,
	input  hashWord_t        header_i,
	input  hashWord_t        target_i,
	input  logic             resValid_i,
	input  logic             resFound_i,
	input  logic [IDX_W-1:0] resIdx_i,
	output logic             stepValid_o,
	output logic             newBlock_o,
	output hashWord_t        header_o,
	output hashWord_t        target_o,
	output logic             resValid_o,
	output logic             resFound_o,
	output logic [IDX_W-1:0] resIdx_o
);
	localparam int LAST = MIX_ROUNDS - 1;

	nonce_t stepCnt;
	nonce_t curStep;
	nonce_t nonce;
	hashWord_t stateQ [MIX_ROUNDS];
	hashWord_t targetQ [MIX_ROUNDS];
	hashWord_t headerQ [MIX_ROUNDS-1];
	logic [MIX_ROUNDS-1:0] validQ;
	logic hit;

	function automatic hashWord_t mixRound(input hashWord_t s, input hashWord_t hdr, input int r);
		hashWord_t t;
		t = {s[24:0], s[31:25]} + hdr;
		return t ^ hashWord_t'(MIX_CONST * (r + 1));
	endfunction

	assign curStep = newBlock_i ? '0 : stepCnt;
	assign nonce = curStep * nonce_t'(NUM_CORES) + nonce_t'(INDEX);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			stepCnt <= '0;
			stepValid_o <= 1'b0;
			newBlock_o <= 1'b0;
			validQ <= '0;
		end else begin
			if (stepValid_i)
				stepCnt <= curStep + 1'b1;
			stepValid_o <= stepValid_i;
			newBlock_o <= newBlock_i;
			validQ <= {validQ[LAST-1:0], stepValid_i};
		end
	end

	always_ff @(posedge clk) begin
		header_o <= header_i;
		target_o <= target_i;
		stateQ[0] <= mixRound(header_i ^ nonce, header_i, 0);
		headerQ[0] <= header_i;
		targetQ[0] <= target_i;
		for (int k = 1; k < MIX_ROUNDS; k++) begin
			stateQ[k] <= mixRound(stateQ[k-1], headerQ[k-1], k);
			targetQ[k] <= targetQ[k-1];
		end
		for (int k = 1; k < MIX_ROUNDS - 1; k++)
			headerQ[k] <= headerQ[k-1];
	end

	assign hit = validQ[LAST] && (stateQ[LAST] < targetQ[LAST]);

	// upstream result of this step arrives together with our hash.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			resValid_o <= 1'b0;
			resFound_o <= 1'b0;
		end else begin
			resValid_o <= resValid_i | validQ[LAST];
			resFound_o <= resFound_i | hit;
		end
	end

	always_ff @(posedge clk) begin
		resIdx_o <= (!resFound_i && hit) ? IDX_W'(INDEX) : resIdx_i; // lower index wins.
	end

	assert property (@(posedge clk) disable iff (rst_i)
		resFound_o |-> (resIdx_o < NUM_CORES));

endmodule

// ==== lattice/latticeChain.sv ====
`timescale 1ns/1ps

module latticeChain import minerPkg::*; #(
	parameter int NUM_CORES = 4,
	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             stepValid_i,
	input  logic             newBlock_i,
	input  hashWord_t        header_i,
	input  hashWord_t        target_i,
	output logic             validOut_o,
	output logic             newBlockOut_o,
	output logic             found_o,
	output logic [IDX_W-1:0] idx_o
);
	// element i feeds core i.
	logic stepGlue [NUM_CORES];
	logic newBlockGlue [NUM_CORES];
	hashWord_t headerGlue [NUM_CORES];
	hashWord_t targetGlue [NUM_CORES];
	logic resValidGlue [NUM_CORES];
	logic resFoundGlue [NUM_CORES];
	logic [IDX_W-1:0] resIdxGlue [NUM_CORES];
	logic tailNewBlock;
	logic [MIX_ROUNDS-1:0] newBlockDly;

	assign stepGlue[0] = stepValid_i;
	assign newBlockGlue[0] = newBlock_i;
	assign headerGlue[0] = header_i;
	assign targetGlue[0] = target_i;
	assign resValidGlue[0] = 1'b0; // nothing upstream of the head.
	assign resFoundGlue[0] = 1'b0;
	assign resIdxGlue[0] = '0;

	for (genvar i = 0; i < NUM_CORES; i++) begin : gCore
		if (i < NUM_CORES - 1) begin : gMid
			latticeCore #(.NUM_CORES(NUM_CORES), .INDEX(i)) core (
				.clk,
				.rst_i,
				.stepValid_i(stepGlue[i]),
				.newBlock_i(newBlockGlue[i]),
				.header_i(headerGlue[i]),
				.target_i(targetGlue[i]),
				.resValid_i(resValidGlue[i]),
				.resFound_i(resFoundGlue[i]),
				.resIdx_i(resIdxGlue[i]),
				.stepValid_o(stepGlue[i+1]),
				.newBlock_o(newBlockGlue[i+1]),
				.header_o(headerGlue[i+1]),
				.target_o(targetGlue[i+1]),
				.resValid_o(resValidGlue[i+1]),
				.resFound_o(resFoundGlue[i+1]),
				.resIdx_o(resIdxGlue[i+1])
			);
		end else begin : gTail
			latticeCore #(.NUM_CORES(NUM_CORES), .INDEX(i)) core (
				.clk,
				.rst_i,
				.stepValid_i(stepGlue[i]),
				.newBlock_i(newBlockGlue[i]),
				.header_i(headerGlue[i]),
				.target_i(targetGlue[i]),
				.resValid_i(resValidGlue[i]),
				.resFound_i(resFoundGlue[i]),
				.resIdx_i(resIdxGlue[i]),
				.stepValid_o(),
				.newBlock_o(tailNewBlock),
				.header_o(),
				.target_o(),
				.resValid_o(validOut_o),
				.resFound_o(found_o),
				.resIdx_o(idx_o)
			);
		end
	end

	// newBlock rides the broadcast path, so bring it level with the tail result.
	always_ff @(posedge clk) begin
		if (rst_i)
			newBlockDly <= '0;
		else
			newBlockDly <= {newBlockDly[MIX_ROUNDS-2:0], tailNewBlock};
	end

	assign newBlockOut_o = newBlockDly[MIX_ROUNDS-1];

	assert property (@(posedge clk) disable iff (rst_i)
		newBlockOut_o |-> validOut_o);

endmodule

// ==== src/nonceDecoder.sv ====
`timescale 1ns/1ps

module nonceDecoder import minerPkg::*; #(
	parameter int NUM_CORES = 4,
	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             valid_i,
	input  logic             newBlock_i,
	input  logic             found_i,
	input  logic [IDX_W-1:0] idx_i,
	output logic             valid_o,
	output logic             success_o,
	output nonce_t           nonce_o
);
	nonce_t stepCnt;
	nonce_t curStep;

	assign curStep = newBlock_i ? '0 : stepCnt; // block restarts at step 0.

	always_ff @(posedge clk) begin
		if (rst_i) begin
			stepCnt <= '0;
			valid_o <= 1'b0;
			success_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			success_o <= valid_i & found_i;
			if (valid_i)
				stepCnt <= curStep + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i)
			nonce_o <= curStep * nonce_t'(NUM_CORES) + nonce_t'(idx_i);
	end

endmodule

// ==== src/nonceBuffer.sv ====
`timescale 1ns/1ps

module nonceBuffer import minerPkg::*; #(
	parameter int BUF_DEPTH = 8
) (
	input  logic   clk,
	input  logic   rst_i,
	input  logic   push_i,
	input  nonce_t nonce_i,
	input  logic   readReady_i,
	output logic   nonceValid_o,
	output nonce_t nonce_o,
	output logic   overflow_o
);
	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	nonce_t mem [BUF_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] fillCnt;
	logic full;
	logic doPush;
	logic doPop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (fillCnt == CNT_W'(BUF_DEPTH));
	assign doPush = push_i && !full; // a full buffer drops the nonce.
	assign doPop = readReady_i && nonceValid_o;
	assign nonceValid_o = (fillCnt != '0);
	assign nonce_o = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= nonce_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCnt <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			fillCnt <= fillCnt + CNT_W'(doPush) - CNT_W'(doPop);
			if (push_i && full)
				overflow_o <= 1'b1; // sticky until reset.
		end
	end

	assert property (@(posedge clk) disable iff (rst_i)
		fillCnt <= CNT_W'(BUF_DEPTH));

endmodule

// ==== src/bcMiner.sv ====
`timescale 1ns/1ps

module bcMiner import minerPkg::*; #(
	parameter int BROADCAST_CNT = 16,
	parameter int NUM_CORES = 4,
	parameter int BUF_DEPTH = 8
) (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      loadBlock_i,
	input  hashWord_t header_i,
	input  hashWord_t target_i,
	input  logic      readReady_i,
	output logic      resultValid_o,
	output logic      success_o,
	output logic      nonceValid_o,
	output nonce_t    nonce_o,
	output logic      overflow_o
);
	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	logic stepValid;
	logic newBlock;
	hashWord_t header;
	hashWord_t target;
	logic validOut;
	logic newBlockOut;
	logic found;
	logic [IDX_W-1:0] idx;
	nonce_t nonce;
	logic push;

	blockStore #(.BROADCAST_CNT(BROADCAST_CNT)) bs (
		.clk,
		.rst_i,
		.loadBlock_i,
		.header_i,
		.target_i,
		.stepValid_o(stepValid),
		.newBlock_o(newBlock),
		.header_o(header),
		.target_o(target)
	);

	latticeChain #(.NUM_CORES(NUM_CORES)) chain (
		.clk,
		.rst_i,
		.stepValid_i(stepValid),
		.newBlock_i(newBlock),
		.header_i(header),
		.target_i(target),
		.validOut_o(validOut),
		.newBlockOut_o(newBlockOut),
		.found_o(found),
		.idx_o(idx)
	);

	nonceDecoder #(.NUM_CORES(NUM_CORES)) ndecode (
		.clk,
		.rst_i,
		.valid_i(validOut),
		.newBlock_i(newBlockOut),
		.found_i(found),
		.idx_i(idx),
		.valid_o(resultValid_o),
		.success_o(success_o),
		.nonce_o(nonce)
	);

	assign push = resultValid_o && success_o; // only successful steps are queued.

	nonceBuffer #(.BUF_DEPTH(BUF_DEPTH)) nbuffer (
		.clk,
		.rst_i,
		.push_i(push),
		.nonce_i(nonce),
		.readReady_i,
		.nonceValid_o,
		.nonce_o,
		.overflow_o
	);

endmodule

// ==== bench/minerModel.svh ====
`ifndef MINER_MODEL_SVH
`define MINER_MODEL_SVH

// reference hash, written from the round rule.
function automatic hashWord_t modelHash(input hashWord_t hdr, input nonce_t n);
	hashWord_t st;
	st = hdr ^ n;
	for (int r = 0; r < MIX_ROUNDS; r++) begin
		st = {st[24:0], st[31:25]} + hdr;
		st = st ^ (MIX_CONST * hashWord_t'(r + 1));
	end
	return st;
endfunction

// per step only the lowest-index hit is kept.
function automatic void buildExpected(input hashWord_t hdr, input hashWord_t tgt);
	nonce_t n;
	expNonces.delete();
	for (int s = 0; s < BROADCAST_CNT; s++) begin
		for (int c = 0; c < NUM_CORES; c++) begin
			n = nonce_t'(s * NUM_CORES + c);
			if (modelHash(hdr, n) < tgt) begin
				expNonces.push_back(n);
				break;
			end
		end
	end
endfunction

// smallest target that still gives two hits in one step.
function automatic hashWord_t pickMultiHitTarget(input hashWord_t hdr);
	hashWord_t best;
	hashWord_t lo1;
	hashWord_t lo2;
	hashWord_t h;
	best = '1;
	for (int s = 0; s < BROADCAST_CNT; s++) begin
		lo1 = '1;
		lo2 = '1;
		for (int c = 0; c < NUM_CORES; c++) begin
			h = modelHash(hdr, nonce_t'(s * NUM_CORES + c));
			if (h < lo1) begin
				lo2 = lo1;
				lo1 = h;
			end else if (h < lo2) begin
				lo2 = h;
			end
		end
		if (lo2 < best)
			best = lo2;
	end
	return (best == '1) ? best : best + 1;
endfunction

`endif

// ==== bench/bcMinerTb.sv ====
`timescale 1ns/1ps

module bcMinerTb import minerPkg::*; ();
	localparam int BROADCAST_CNT = 16;
	localparam int NUM_CORES = 4;
	localparam int BUF_DEPTH = 8;
	localparam int NUM_TESTS = 5;
	localparam int SEED = 91594;
	localparam int RESULT_TIMEOUT = BROADCAST_CNT + MIX_ROUNDS + NUM_CORES + 20;
	localparam int READ_TIMEOUT = 20;
	localparam int HOLD_CYCLES = 6;

	logic clk;
	logic rst_i;
	logic loadBlock_i;
	hashWord_t header_i;
	hashWord_t target_i;
	logic readReady_i;
	logic resultValid_o;
	logic success_o;
	logic nonceValid_o;
	nonce_t nonce_o;
	logic overflow_o;

	nonce_t expNonces[$];
	logic expOverflow;

	string rowName [NUM_TESTS];
	hashWord_t rowHeader [NUM_TESTS];
	bit rowRandHdr [NUM_TESTS];
	hashWord_t rowTarget [NUM_TESTS];
	bit rowPickTarget [NUM_TESTS];
	bit rowHold [NUM_TESTS];

	`include "minerModel.svh"

	bcMiner #(
		.BROADCAST_CNT(BROADCAST_CNT),
		.NUM_CORES(NUM_CORES),
		.BUF_DEPTH(BUF_DEPTH)
	) dut (
		.clk,
		.rst_i,
		.loadBlock_i,
		.header_i,
		.target_i,
		.readReady_i,
		.resultValid_o,
		.success_o,
		.nonceValid_o,
		.nonce_o,
		.overflow_o
	);

	always #4 clk = ~clk;

	task automatic failRun();
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkNonce(input string name, input nonce_t expVal, input nonce_t actVal);
		if (expVal !== actVal) begin
			$display("Mismatch %s nonce_o: expected %08h, actual %08h", name, expVal, actVal);
			failRun();
		end
	endtask

	task automatic checkFlag(input string name, input string what, input logic expVal,
		input logic actVal);
		if (expVal !== actVal) begin
			$display("Mismatch %s %s: expected %b, actual %b", name, what, expVal, actVal);
			failRun();
		end
	endtask

	task automatic checkCount(input string name, input string what, input int expVal,
		input int actVal);
		if (expVal != actVal) begin
			$display("Mismatch %s %s: expected %0d, actual %0d", name, what, expVal, actVal);
			failRun();
		end
	endtask

	task automatic setRow(input int i, input string name, input hashWord_t hdr, input bit rnd,
		input hashWord_t tgt, input bit pick, input bit hold);
		rowName[i] = name;
		rowHeader[i] = hdr;
		rowRandHdr[i] = rnd;
		rowTarget[i] = tgt;
		rowPickTarget[i] = pick;
		rowHold[i] = hold;
	endtask

	task automatic drainBuffer(input string name);
		int expLen;
		int waitCyc;
		expLen = (expNonces.size() > BUF_DEPTH) ? BUF_DEPTH : expNonces.size();
		for (int k = 0; k < expLen; k++) begin
			waitCyc = 0;
			while (!nonceValid_o) begin
				if (waitCyc >= READ_TIMEOUT) begin
					$display("Timeout in %s: buffer went empty after %0d of %0d reads",
						name, k, expLen);
					failRun();
				end
				@(negedge clk);
				waitCyc++;
			end
			checkNonce(name, expNonces[k], nonce_o);
			@(posedge clk);
			readReady_i <= 1'b1;
			@(posedge clk);
			readReady_i <= 1'b0;
			@(negedge clk);
		end
		checkFlag(name, "nonceValid_o after drain", 1'b0, nonceValid_o);
	endtask

	task automatic runRow(input int r);
		hashWord_t hdr;
		hashWord_t tgt;
		int validCnt;
		int successCnt;
		int waitCyc;
		hdr = rowRandHdr[r] ? hashWord_t'($urandom()) : rowHeader[r];
		tgt = rowPickTarget[r] ? pickMultiHitTarget(hdr) : rowTarget[r];
		buildExpected(hdr, tgt);
		if (expNonces.size() > BUF_DEPTH)
			expOverflow = 1'b1; // sticky in the DUT too.
		@(posedge clk);
		loadBlock_i <= 1'b1;
		header_i <= hdr;
		target_i <= tgt;
		@(posedge clk);
		loadBlock_i <= 1'b0;
		validCnt = 0;
		successCnt = 0;
		waitCyc = 0;
		@(negedge clk);
		while (!resultValid_o) begin
			if (waitCyc >= RESULT_TIMEOUT) begin
				$display("Timeout in %s: no step result arrived", rowName[r]);
				failRun();
			end
			if (success_o)
				successCnt++;
			@(negedge clk);
			waitCyc++;
		end
		// step results come back as one unbroken run.
		while (resultValid_o) begin
			if (waitCyc >= RESULT_TIMEOUT) begin
				$display("Timeout in %s: resultValid_o still high after %0d pulses",
					rowName[r], validCnt);
				failRun();
			end
			validCnt++;
			if (success_o)
				successCnt++;
			@(negedge clk);
			waitCyc++;
		end
		checkCount(rowName[r], "result pulses", BROADCAST_CNT, validCnt);
		checkCount(rowName[r], "successful steps", expNonces.size(), successCnt);
		checkFlag(rowName[r], "overflow_o", expOverflow, overflow_o);
		checkFlag(rowName[r], "nonceValid_o", expNonces.size() != 0, nonceValid_o);
		if (rowHold[r]) begin
			repeat (HOLD_CYCLES) @(negedge clk);
			checkFlag(rowName[r], "nonceValid_o while held", expNonces.size() != 0,
				nonceValid_o);
		end
		drainBuffer(rowName[r]);
		checkFlag(rowName[r], "overflow_o after drain", expOverflow, overflow_o);
	endtask

	initial begin
		clk = 1'b0;
		rst_i = 1'b1;
		loadBlock_i = 1'b0;
		header_i = '0;
		target_i = '0;
		readReady_i = 1'b0;
		expOverflow = 1'b0;
		void'($urandom(SEED));

		setRow(0, "zeroTarget", 32'h01234567, 1'b0, 32'h00000000, 1'b0, 1'b0);
		setRow(1, "midTarget", 32'h0, 1'b1, 32'h10000000, 1'b0, 1'b0);
		setRow(2, "multiHit", 32'h5A17C3E9, 1'b0, 32'h0, 1'b1, 1'b0);
		setRow(3, "secondBlock", 32'h0, 1'b1, 32'h18000000, 1'b0, 1'b0);
		setRow(4, "fullTarget", 32'h3C5A96E1, 1'b0, 32'hFFFFFFFF, 1'b0, 1'b1);

		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		checkFlag("reset", "resultValid_o", 1'b0, resultValid_o);
		checkFlag("reset", "success_o", 1'b0, success_o);
		checkFlag("reset", "nonceValid_o", 1'b0, nonceValid_o);
		checkFlag("reset", "overflow_o", 1'b0, overflow_o);

		for (int r = 0; r < NUM_TESTS; r++)
			runRow(r);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+bench
common/minerPkg.sv
src/blockStore.sv
lattice/latticeCore.sv
lattice/latticeChain.sv
src/nonceDecoder.sv
src/nonceBuffer.sv
src/bcMiner.sv
bench/bcMinerTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f flist.f --top-module bcMinerTb --Mdir obj_dir -o bcMinerSim

./obj_dir/bcMinerSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
